// ==== qsfp_pkg.sv ====
// QSFP port shared definitions
package qsfp_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  localparam int NUM_LANES    = 4;
  localparam int LANE_W       = $clog2(NUM_LANES);
  localparam int REG_DW       = 32;
  localparam int REG_AW       = 12;
  localparam int LANE_SEL_LSB = 10;
  localparam int CHDR_W       = 64;
  localparam int MODE_W       = 2;

  // Activity stretch length and its down-counter width
  localparam int ACT_HOLD     = 16;
  localparam int ACT_CNT_W    = $clog2(ACT_HOLD + 1);

  // ----------------------------------------
  // Register map within one lane window
  // ----------------------------------------
  localparam logic [REG_AW-1:0] REG_PORT_INFO = 12'h000;
  localparam logic [REG_AW-1:0] REG_CTRL      = 12'h004;
  localparam logic [REG_AW-1:0] REG_RX_PKTS   = 12'h008;
  localparam logic [REG_AW-1:0] REG_TX_PKTS   = 12'h00C;

  // Returned for offsets that map to nothing
  localparam logic [REG_DW-1:0] REG_BAD_DATA  = 32'hBAD0_0000;

  // Port number reported in port info bits 7:0
  localparam logic [7:0] PORT_NUM = 8'd0;

  // Lane modes, codes 2 and 3 behave as disabled
  localparam logic [MODE_W-1:0] MODE_DISABLED = 2'd0;
  localparam logic [MODE_W-1:0] MODE_PASSTHRU = 2'd1;

  // ----------------------------------------
  // Bundled types
  // ----------------------------------------

  // One-cycle register request
  typedef struct packed {
    logic              wr_req;
    logic              rd_req;
    logic [REG_AW-1:0] addr;
    logic [REG_DW-1:0] wdata;
  } reg_req_t;

  // Read response, rdata only meaningful with resp high
  typedef struct packed {
    logic              resp;
    logic [REG_DW-1:0] rdata;
  } reg_resp_t;

  // Stream beat without its handshake
  typedef struct packed {
    logic [CHDR_W-1:0] data;
    logic              last;
  } axis_beat_t;

endpackage

// ==== qsfp_reg_decode.sv ====
// Register port lane decoder
`timescale 1ns/1ps

module qsfp_reg_decode
  import qsfp_pkg::*;
(
  input  logic                        bus_clk_i,
  input  logic                        rst_n_i,
  input  reg_req_t                    host_req_i,
  output reg_resp_t                   host_resp_o,
  output reg_req_t  [NUM_LANES-1:0]   lane_req_o,
  input  reg_resp_t [NUM_LANES-1:0]   lane_resp_i
);

  // ----------------------------------------
  // Request stage
  // ----------------------------------------
  logic              req_wr_q;
  logic              req_rd_q;
  logic [REG_AW-1:0] req_addr_q;
  logic [REG_DW-1:0] req_wdata_q;
  logic [LANE_W-1:0] lane_sel;

  always_ff @(posedge bus_clk_i) begin
    if (!rst_n_i) begin
      req_wr_q <= 1'b0;
      req_rd_q <= 1'b0;
    end else begin
      req_wr_q <= host_req_i.wr_req;
      req_rd_q <= host_req_i.rd_req;
    end
  end

  always_ff @(posedge bus_clk_i) begin
    req_addr_q  <= host_req_i.addr;
    req_wdata_q <= host_req_i.wdata;
  end

  assign lane_sel = req_addr_q[REG_AW-1:LANE_SEL_LSB];

  // Steer strobes to one lane, lane bits dropped from the address
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_req_o[i].wr_req = req_wr_q && (lane_sel == LANE_W'(i));
      lane_req_o[i].rd_req = req_rd_q && (lane_sel == LANE_W'(i));
      lane_req_o[i].addr   = req_addr_q;
      lane_req_o[i].addr[REG_AW-1:LANE_SEL_LSB] = '0;
      lane_req_o[i].wdata  = req_wdata_q;
    end
  end

  // ----------------------------------------
  // Response merge
  // ----------------------------------------
  logic              resp_any;
  logic [REG_DW-1:0] rdata_any;
  logic              resp_q;
  logic [REG_DW-1:0] rdata_q;

  // Data masked by its own pulse so idle lanes add nothing
  always_comb begin
    resp_any  = 1'b0;
    rdata_any = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      resp_any  = resp_any | lane_resp_i[i].resp;
      rdata_any = rdata_any | (lane_resp_i[i].rdata & {REG_DW{lane_resp_i[i].resp}});
    end
  end

  always_ff @(posedge bus_clk_i) begin
    if (!rst_n_i) begin
      resp_q <= 1'b0;
    end else begin
      resp_q <= resp_any;
    end
  end

  always_ff @(posedge bus_clk_i) begin
    rdata_q <= rdata_any;
  end

  assign host_resp_o.resp  = resp_q;
  assign host_resp_o.rdata = rdata_q;

endmodule

// ==== qsfp_lane_regs.sv ====
// Lane control and status registers
`timescale 1ns/1ps

module qsfp_lane_regs
  import qsfp_pkg::*;
#(
  parameter int LANE_IDX = 0
) (
  input  logic              bus_clk_i,
  input  logic              rst_n_i,
  input  reg_req_t          req_i,
  output reg_resp_t         resp_o,
  output logic [MODE_W-1:0] mode_o,
  input  logic              link_up_i,
  input  logic              activity_i,
  input  logic              rx_pkt_i,
  input  logic              tx_pkt_i,
  output logic [REG_DW-1:0] port_info_o
);

  logic [MODE_W-1:0]             mode_q;
  logic [1:0][REG_DW-1:0]        pkt_cnt_q;
  logic [1:0]                    cnt_clr;
  logic [1:0]                    cnt_inc;
  logic [REG_DW-1:0]             rd_data;
  logic                          resp_q;
  logic [REG_DW-1:0]             rdata_q;

  // ----------------------------------------
  // Control register
  // ----------------------------------------
  always_ff @(posedge bus_clk_i) begin
    if (!rst_n_i) begin
      mode_q <= MODE_DISABLED;
    end else if (req_i.wr_req && (req_i.addr == REG_CTRL)) begin
      mode_q <= req_i.wdata[MODE_W-1:0];
    end
  end

  assign mode_o = mode_q;

  // ----------------------------------------
  // Packet counters, index 0 rx and 1 tx
  // ----------------------------------------
  assign cnt_clr[0] = req_i.wr_req && (req_i.addr == REG_RX_PKTS);
  assign cnt_clr[1] = req_i.wr_req && (req_i.addr == REG_TX_PKTS);
  assign cnt_inc    = {tx_pkt_i, rx_pkt_i};

  // A clear wins over a packet in the same cycle
  always_ff @(posedge bus_clk_i) begin
    for (int i = 0; i < 2; i++) begin
      if (!rst_n_i || cnt_clr[i]) begin
        pkt_cnt_q[i] <= '0;
      end else if (cnt_inc[i]) begin
        pkt_cnt_q[i] <= pkt_cnt_q[i] + 1'b1;
      end
    end
  end

  // Port info word
  assign port_info_o = {14'b0, activity_i, link_up_i, 2'b0, mode_q,
                        2'b0, LANE_W'(LANE_IDX), PORT_NUM};

  // ----------------------------------------
  // Read path
  // ----------------------------------------
  always_comb begin
    case (req_i.addr)
      REG_PORT_INFO: rd_data = port_info_o;
      REG_CTRL:      rd_data = {{(REG_DW-MODE_W){1'b0}}, mode_q};
      REG_RX_PKTS:   rd_data = pkt_cnt_q[0];
      REG_TX_PKTS:   rd_data = pkt_cnt_q[1];
      default:       rd_data = REG_BAD_DATA;
    endcase
  end

  always_ff @(posedge bus_clk_i) begin
    if (!rst_n_i) begin
      resp_q <= 1'b0;
    end else begin
      resp_q <= req_i.rd_req;
    end
  end

  always_ff @(posedge bus_clk_i) begin
    if (req_i.rd_req) begin
      rdata_q <= rd_data;
    end
  end

  assign resp_o.resp  = resp_q;
  assign resp_o.rdata = rdata_q;

endmodule

// ==== qsfp_lane_stream.sv ====
// Lane stream routing and status
`timescale 1ns/1ps

module qsfp_lane_stream
  import qsfp_pkg::*;
(
  input  logic              bus_clk_i,
  input  logic              rst_n_i,
  input  logic [MODE_W-1:0] mode_i,
  input  logic              link_ok_i,
  input  axis_beat_t        rx_beat_i,
  input  logic              rx_valid_i,
  output logic              rx_ready_o,
  output axis_beat_t        e2v_beat_o,
  output logic              e2v_valid_o,
  input  logic              e2v_ready_i,
  input  axis_beat_t        v2e_beat_i,
  input  logic              v2e_valid_i,
  output logic              v2e_ready_o,
  output axis_beat_t        tx_beat_o,
  output logic              tx_valid_o,
  input  logic              tx_ready_i,
  output logic              link_up_o,
  output logic              activity_o,
  output logic              rx_pkt_o,
  output logic              tx_pkt_o
);

  logic                 pass;
  logic                 rx_xfer;
  logic                 tx_xfer;
  logic [ACT_CNT_W-1:0] act_cnt_q;

  // Codes other than passthrough all sink
  assign pass = (mode_i == MODE_PASSTHRU);

  // ----------------------------------------
  // Routing
  // ----------------------------------------
  // Serial link towards router
  assign e2v_beat_o  = pass ? rx_beat_i : '0;
  assign e2v_valid_o = pass && rx_valid_i;
  assign rx_ready_o  = pass ? e2v_ready_i : 1'b1;

  // Router towards serial link
  assign tx_beat_o   = pass ? v2e_beat_i : '0;
  assign tx_valid_o  = pass && v2e_valid_i;
  assign v2e_ready_o = pass ? tx_ready_i : 1'b1;

  // Only forwarded beats count, sunk ones are dropped silently
  assign rx_xfer  = e2v_valid_o && e2v_ready_i;
  assign tx_xfer  = tx_valid_o && tx_ready_i;
  assign rx_pkt_o = rx_xfer && rx_beat_i.last;
  assign tx_pkt_o = tx_xfer && v2e_beat_i.last;

  // ----------------------------------------
  // Status
  // ----------------------------------------
  assign link_up_o = pass && link_ok_i;

  // Reload on any transfer, then count down to idle
  always_ff @(posedge bus_clk_i) begin
    if (!rst_n_i) begin
      act_cnt_q <= '0;
    end else if (rx_xfer || tx_xfer) begin
      act_cnt_q <= ACT_CNT_W'(ACT_HOLD);
    end else if (act_cnt_q != '0) begin
      act_cnt_q <= act_cnt_q - 1'b1;
    end
  end

  assign activity_o = (act_cnt_q != '0);

endmodule

// ==== qsfp_port_top.sv ====
// QSFP four-lane port top level
`timescale 1ns/1ps

module qsfp_port_top
  import qsfp_pkg::*;
(
  input  logic                                bus_clk_i,
  input  logic                                rst_n_i,
  input  reg_req_t                            host_req_i,
  output reg_resp_t                           host_resp_o,
  input  logic       [NUM_LANES-1:0]          link_ok_i,
  // Serial link to lane
  input  axis_beat_t [NUM_LANES-1:0]          rx_beat_i,
  input  logic       [NUM_LANES-1:0]          rx_valid_i,
  output logic       [NUM_LANES-1:0]          rx_ready_o,
  // Lane to router
  output axis_beat_t [NUM_LANES-1:0]          e2v_beat_o,
  output logic       [NUM_LANES-1:0]          e2v_valid_o,
  input  logic       [NUM_LANES-1:0]          e2v_ready_i,
  // Router to lane
  input  axis_beat_t [NUM_LANES-1:0]          v2e_beat_i,
  input  logic       [NUM_LANES-1:0]          v2e_valid_i,
  output logic       [NUM_LANES-1:0]          v2e_ready_o,
  // Lane to serial link
  output axis_beat_t [NUM_LANES-1:0]          tx_beat_o,
  output logic       [NUM_LANES-1:0]          tx_valid_o,
  input  logic       [NUM_LANES-1:0]          tx_ready_i,
  // Status
  output logic       [NUM_LANES-1:0][REG_DW-1:0] port_info_o,
  output logic       [NUM_LANES-1:0]          link_up_o,
  output logic       [NUM_LANES-1:0]          activity_o
);

  reg_req_t  [NUM_LANES-1:0]             lane_req;
  reg_resp_t [NUM_LANES-1:0]             lane_resp;
  logic      [NUM_LANES-1:0][MODE_W-1:0] lane_mode;
  logic      [NUM_LANES-1:0]             rx_pkt;
  logic      [NUM_LANES-1:0]             tx_pkt;

  qsfp_reg_decode u_reg_decode (
    .bus_clk_i   (bus_clk_i),
    .rst_n_i     (rst_n_i),
    .host_req_i  (host_req_i),
    .host_resp_o (host_resp_o),
    .lane_req_o  (lane_req),
    .lane_resp_i (lane_resp)
  );

  // ----------------------------------------
  // One register window and data path per lane
  // ----------------------------------------
  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane

    qsfp_lane_regs #(
      .LANE_IDX (lane)
    ) u_lane_regs (
      .bus_clk_i   (bus_clk_i),
      .rst_n_i     (rst_n_i),
      .req_i       (lane_req[lane]),
      .resp_o      (lane_resp[lane]),
      .mode_o      (lane_mode[lane]),
      .link_up_i   (link_up_o[lane]),
      .activity_i  (activity_o[lane]),
      .rx_pkt_i    (rx_pkt[lane]),
      .tx_pkt_i    (tx_pkt[lane]),
      .port_info_o (port_info_o[lane])
    );

    qsfp_lane_stream u_lane_stream (
      .bus_clk_i   (bus_clk_i),
      .rst_n_i     (rst_n_i),
      .mode_i      (lane_mode[lane]),
      .link_ok_i   (link_ok_i[lane]),
      .rx_beat_i   (rx_beat_i[lane]),
      .rx_valid_i  (rx_valid_i[lane]),
      .rx_ready_o  (rx_ready_o[lane]),
      .e2v_beat_o  (e2v_beat_o[lane]),
      .e2v_valid_o (e2v_valid_o[lane]),
      .e2v_ready_i (e2v_ready_i[lane]),
      .v2e_beat_i  (v2e_beat_i[lane]),
      .v2e_valid_i (v2e_valid_i[lane]),
      .v2e_ready_o (v2e_ready_o[lane]),
      .tx_beat_o   (tx_beat_o[lane]),
      .tx_valid_o  (tx_valid_o[lane]),
      .tx_ready_i  (tx_ready_i[lane]),
      .link_up_o   (link_up_o[lane]),
      .activity_o  (activity_o[lane]),
      .rx_pkt_o    (rx_pkt[lane]),
      .tx_pkt_o    (tx_pkt[lane])
    );

  end : g_lane

endmodule

// ==== tb_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held low for four rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== qsfp_port_chk.sv ====
// QSFP port protocol checker
`timescale 1ns/1ps

module qsfp_port_chk
  import qsfp_pkg::*;
(
  input logic                             bus_clk_i,
  input logic                             rst_n_i,
  input reg_req_t                         host_req_i,
  input reg_resp_t                        host_resp_i,
  input logic [NUM_LANES-1:0][MODE_W-1:0] mode_i,
  input axis_beat_t [NUM_LANES-1:0]       e2v_beat_i,
  input logic [NUM_LANES-1:0]             e2v_valid_i,
  input logic [NUM_LANES-1:0]             e2v_ready_i,
  input axis_beat_t [NUM_LANES-1:0]       tx_beat_i,
  input logic [NUM_LANES-1:0]             tx_valid_i,
  input logic [NUM_LANES-1:0]             tx_ready_i
);

  // Every read answered exactly three cycles later, and nothing else answered
  a_read_resp: assert property (@(posedge bus_clk_i) disable iff (!rst_n_i)
    host_resp_i.resp == $past(host_req_i.rd_req, 3))
    else $error("read response not three cycles after its request");

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    a_e2v_hold: assert property (@(posedge bus_clk_i) disable iff (!rst_n_i)
      e2v_valid_i[i] && !e2v_ready_i[i] |=> e2v_valid_i[i] && $stable(e2v_beat_i[i]))
      else $error("stalled e2v beat changed on lane %0d", i);

    a_tx_hold: assert property (@(posedge bus_clk_i) disable iff (!rst_n_i)
      tx_valid_i[i] && !tx_ready_i[i] |=> tx_valid_i[i] && $stable(tx_beat_i[i]))
      else $error("stalled tx beat changed on lane %0d", i);

    // Sinking lanes send nothing in either direction
    a_off_quiet: assert property (@(posedge bus_clk_i) disable iff (!rst_n_i)
      mode_i[i] != MODE_PASSTHRU |-> !e2v_valid_i[i] && !tx_valid_i[i])
      else $error("disabled lane %0d raised a valid", i);
  end : g_lane

endmodule

bind qsfp_port_top qsfp_port_chk u_qsfp_port_chk (
  .bus_clk_i   (bus_clk_i),
  .rst_n_i     (rst_n_i),
  .host_req_i  (host_req_i),
  .host_resp_i (host_resp_o),
  .mode_i      (lane_mode),
  .e2v_beat_i  (e2v_beat_o),
  .e2v_valid_i (e2v_valid_o),
  .e2v_ready_i (e2v_ready_i),
  .tx_beat_i   (tx_beat_o),
  .tx_valid_i  (tx_valid_o),
  .tx_ready_i  (tx_ready_i)
);

// ==== tb_qsfp_port.sv ====
// QSFP port directed testbench
`timescale 1ns/1ps

module tb_qsfp_port
  import qsfp_pkg::*;
();

  // About 2500 cycles covers all tests with a wide margin
  localparam int TEST_CYCLES = 2500;
  localparam int WATCHDOG_NS = TEST_CYCLES * 8;

  logic                             bus_clk;
  logic                             rst_n;
  reg_req_t                         host_req;
  reg_resp_t                        host_resp;
  logic       [NUM_LANES-1:0]       link_ok;
  axis_beat_t [NUM_LANES-1:0]       rx_beat;
  axis_beat_t [NUM_LANES-1:0]       e2v_beat;
  axis_beat_t [NUM_LANES-1:0]       v2e_beat;
  axis_beat_t [NUM_LANES-1:0]       tx_beat;
  logic       [NUM_LANES-1:0]       rx_valid;
  logic       [NUM_LANES-1:0]       rx_ready;
  logic       [NUM_LANES-1:0]       e2v_valid;
  logic       [NUM_LANES-1:0]       e2v_ready;
  logic       [NUM_LANES-1:0]       v2e_valid;
  logic       [NUM_LANES-1:0]       v2e_ready;
  logic       [NUM_LANES-1:0]       tx_valid;
  logic       [NUM_LANES-1:0]       tx_ready;
  logic [NUM_LANES-1:0][REG_DW-1:0] port_info;
  logic       [NUM_LANES-1:0]       link_up;
  logic       [NUM_LANES-1:0]       activity;
  int                               errors = 0;
  int                               seed = 32'h6446;

  tb_clk_gen u_clk_gen (
    .clk_o   (bus_clk),
    .rst_n_o (rst_n)
  );

  qsfp_port_top u_qsfp_port_top (
    .bus_clk_i   (bus_clk),     .rst_n_i     (rst_n),
    .host_req_i  (host_req),    .host_resp_o (host_resp),
    .link_ok_i   (link_ok),
    .rx_beat_i   (rx_beat),     .rx_valid_i  (rx_valid),  .rx_ready_o  (rx_ready),
    .e2v_beat_o  (e2v_beat),    .e2v_valid_o (e2v_valid), .e2v_ready_i (e2v_ready),
    .v2e_beat_i  (v2e_beat),    .v2e_valid_i (v2e_valid), .v2e_ready_o (v2e_ready),
    .tx_beat_o   (tx_beat),     .tx_valid_o  (tx_valid),  .tx_ready_i  (tx_ready),
    .port_info_o (port_info),   .link_up_o   (link_up),   .activity_o  (activity)
  );

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic reg_write(input logic [1:0] lane, input logic [REG_AW-1:0] off,
                           input logic [REG_DW-1:0] data);
    @(negedge bus_clk);
    host_req.wr_req = 1'b1;
    host_req.addr   = {lane, off[LANE_SEL_LSB-1:0]};
    host_req.wdata  = data;
    @(negedge bus_clk);
    host_req.wr_req = 1'b0;
  endtask

  // Waits for the response pulse, which must come three cycles after the request
  task automatic reg_read(input logic [1:0] lane, input logic [REG_AW-1:0] off,
                          output logic [REG_DW-1:0] data);
    int wait_cyc;
    @(negedge bus_clk);
    host_req.rd_req = 1'b1;
    host_req.addr   = {lane, off[LANE_SEL_LSB-1:0]};
    @(negedge bus_clk);
    host_req.rd_req = 1'b0;
    wait_cyc = 1;
    while (!host_resp.resp && wait_cyc < 16) begin
      @(negedge bus_clk);
      wait_cyc++;
    end
    assert (host_resp.resp) else begin
      errors++;
      $display("read of lane %0d offset %h got no response", lane, off);
    end
    check_eq("read latency", wait_cyc, 3);
    data = host_resp.rdata;
  endtask

  task automatic check_read(input logic [1:0] lane, input logic [REG_AW-1:0] off,
                            input logic [REG_DW-1:0] exp, input string what);
    logic [REG_DW-1:0] rd;
    reg_read(lane, off, rd);
    check_eq(what, rd, exp);
  endtask

  // Packets of one to four random beats
  task automatic make_packets(input int npkts, output axis_beat_t q[$]);
    axis_beat_t beat;
    int         len;
    q.delete();
    for (int p = 0; p < npkts; p++) begin
      len = 1 + ($unsigned($random(seed)) % 4);
      for (int b = 0; b < len; b++) begin
        beat.data = {$random(seed), $random(seed)};
        beat.last = (b == len - 1);
        q.push_back(beat);
      end
    end
  endtask

  task automatic compare_stream(input string what, input axis_beat_t got[$],
                                input axis_beat_t exp[$]);
    assert (got.size() == exp.size()) else begin
      errors++;
      $display("mismatch at %0t ns: %s carried %0d beats, expected %0d",
               $time, what, got.size(), exp.size());
    end
    for (int i = 0; i < got.size() && i < exp.size(); i++) begin
      check_eq({what, " data"}, got[i].data, exp[i].data);
      check_eq({what, " last"}, got[i].last, exp[i].last);
    end
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic reset_state();
    check_eq("ready after reset", {rx_ready, v2e_ready}, 8'hFF);
    check_eq("valid and status after reset", {e2v_valid, tx_valid, link_up, activity}, 16'h0);
    check_eq("response after reset", host_resp.resp, 1'b0);
    for (int l = 0; l < NUM_LANES; l++) begin
      // Port number, lane index, disabled mode and link down
      check_read(2'(l), REG_PORT_INFO, (32'(l) << 8) | 32'(PORT_NUM), "port info");
      check_read(2'(l), REG_CTRL, 32'd0, "ctrl after reset");
    end
  endtask

  task automatic mode_link();
    logic [REG_DW-1:0] rd;
    logic [REG_DW-1:0] exp_info;
    reg_write(2'd1, REG_CTRL, 32'(MODE_PASSTHRU));
    reg_write(2'd3, REG_CTRL, 32'(MODE_PASSTHRU));
    for (int l = 0; l < NUM_LANES; l++) begin
      check_read(2'(l), REG_CTRL, (l % 2 == 1) ? 32'd1 : 32'd0, "ctrl readback");
    end
    for (int p = 0; p < 4; p++) begin
      @(negedge bus_clk);
      link_ok = 4'(p * 5);
      @(negedge bus_clk);
      // Only lanes 1 and 3 are in passthrough
      check_eq("link up", link_up, link_ok & 4'b1010);
      for (int l = 0; l < NUM_LANES; l++) begin
        // No traffic yet, so the activity bit stays clear
        exp_info = (32'(l) << 8) | 32'(PORT_NUM);
        if (l % 2 == 1) begin
          exp_info = exp_info | (32'(MODE_PASSTHRU) << 12) | (32'(link_ok[l]) << 16);
        end
        check_eq("port info output", port_info[l], exp_info);
        reg_read(2'(l), REG_PORT_INFO, rd);
        check_eq("port info read", rd, exp_info);
      end
    end
  endtask

  task automatic pass_data(input logic [1:0] lane, input int npkts);
    axis_beat_t rx_q[$];
    axis_beat_t v2e_q[$];
    axis_beat_t e2v_got[$];
    axis_beat_t tx_got[$];
    int         ri;
    int         vi;
    int         cyc;
    make_packets(npkts, rx_q);
    make_packets(npkts, v2e_q);
    ri  = 0;
    vi  = 0;
    cyc = 0;
    while ((ri < rx_q.size() || vi < v2e_q.size()) && cyc < 1000) begin
      @(negedge bus_clk);
      // Handshakes completed on the last rising edge
      check_eq("rx ready follows e2v ready", rx_ready[lane], e2v_ready[lane]);
      check_eq("v2e ready follows tx ready", v2e_ready[lane], tx_ready[lane]);
      if (e2v_valid[lane] && e2v_ready[lane]) e2v_got.push_back(e2v_beat[lane]);
      if (tx_valid[lane] && tx_ready[lane]) tx_got.push_back(tx_beat[lane]);
      if (rx_valid[lane] && rx_ready[lane]) ri++;
      if (v2e_valid[lane] && v2e_ready[lane]) vi++;
      rx_valid[lane]  = (ri < rx_q.size());
      v2e_valid[lane] = (vi < v2e_q.size());
      if (ri < rx_q.size()) rx_beat[lane] = rx_q[ri];
      if (vi < v2e_q.size()) v2e_beat[lane] = v2e_q[vi];
      // Full stall first, then random back-pressure
      e2v_ready[lane] = (cyc >= 6) && ($random(seed) % 2 != 0);
      tx_ready[lane]  = (cyc >= 6) && ($random(seed) % 2 != 0);
      cyc++;
    end
    assert (cyc < 1000) else begin
      errors++;
      $display("stream transfers on lane %0d did not finish in time", lane);
    end
    e2v_ready[lane] = 1'b1;
    tx_ready[lane]  = 1'b1;
    compare_stream("rx to e2v", e2v_got, rx_q);
    compare_stream("v2e to tx", tx_got, v2e_q);
  endtask

  // Lane 0 left at reset, lane 2 given code 2 which also sinks
  task automatic disabled_sink();
    logic [1:0] lane;
    reg_write(2'd2, REG_CTRL, 32'd2);
    check_read(2'd2, REG_CTRL, 32'd2, "ctrl code 2 readback");
    for (int k = 0; k < 2; k++) begin
      lane = 2'(k * 2);
      for (int c = 0; c < 9; c++) begin
        @(negedge bus_clk);
        check_eq("sink rx ready", rx_ready[lane], 1'b1);
        check_eq("sink v2e ready", v2e_ready[lane], 1'b1);
        check_eq("sink e2v valid", e2v_valid[lane], 1'b0);
        check_eq("sink tx valid", tx_valid[lane], 1'b0);
        rx_valid[lane]  = (c < 8);
        v2e_valid[lane] = (c < 8);
        rx_beat[lane]   = {$random(seed), $random(seed), 1'b1};
        v2e_beat[lane]  = {$random(seed), $random(seed), 1'b1};
        e2v_ready[lane] = (c % 2 == 1) || (c == 8);
        tx_ready[lane]  = (c % 2 == 1) || (c == 8);
      end
      check_read(lane, REG_RX_PKTS, 32'd0, "sink rx count");
      check_read(lane, REG_TX_PKTS, 32'd0, "sink tx count");
    end
  endtask

  task automatic packet_counters(input logic [1:0] lane, input int npkts);
    reg_write(lane, REG_RX_PKTS, 32'd0);
    reg_write(lane, REG_TX_PKTS, 32'd0);
    pass_data(lane, npkts);
    check_read(lane, REG_RX_PKTS, 32'(npkts), "rx packet count");
    check_read(lane, REG_TX_PKTS, 32'(npkts), "tx packet count");
    reg_write(lane, REG_RX_PKTS, 32'd0);
    reg_write(lane, REG_TX_PKTS, 32'd0);
    check_read(lane, REG_RX_PKTS, 32'd0, "rx count after clear");
    check_read(lane, REG_TX_PKTS, 32'd0, "tx count after clear");
  endtask

  task automatic activity_unmapped();
    @(negedge bus_clk);
    rx_beat[1]  = {$random(seed), $random(seed), 1'b1};
    rx_valid[1] = 1'b1;
    @(negedge bus_clk);
    rx_valid[1] = 1'b0;
    check_eq("activity after transfer", activity[1], 1'b1);
    check_eq("port info activity bit set", port_info[1][17], 1'b1);
    repeat (ACT_HOLD - 1) @(negedge bus_clk);
    check_eq("activity near end of hold", activity[1], 1'b1);
    repeat (2) @(negedge bus_clk);
    check_eq("activity after idle", activity[1], 1'b0);
    check_eq("port info activity bit clear", port_info[1][17], 1'b0);
    check_read(2'd0, 12'h010, 32'hBAD0_0000, "unmapped offset");
  endtask

  // ----------------------------------------
  // Sequence and watchdog
  // ----------------------------------------
  initial begin
    host_req  = '0;
    link_ok   = '1;
    rx_beat   = '0;
    rx_valid  = '0;
    e2v_ready = '1;
    v2e_beat  = '0;
    v2e_valid = '0;
    tx_ready  = '1;
    wait (rst_n === 1'b1);
    reset_state();
    mode_link();
    pass_data(2'd1, 6);
    disabled_sink();
    packet_counters(2'd3, 5);
    activity_unmapped();
    @(negedge bus_clk);
    $display("tests done, errors: %0d", errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished, errors: %0d", errors);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== project.f ====
qsfp_pkg.sv
qsfp_reg_decode.sv
qsfp_lane_regs.sv
qsfp_lane_stream.sv
qsfp_port_top.sv
tb_clk_gen.sv
qsfp_port_chk.sv
tb_qsfp_port.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_qsfp_port \
  -f project.f -o sim_qsfp_port
./obj_dir/sim_qsfp_port | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation finished without failures"
